/* src.f */
riscv_pkg.sv
decode_if.sv
operand_if.sv
control.sv
decode_stage.sv
reg_file.sv
operand_stage.sv
execute_stage.sv
int_pipeline_top.sv
tb_int_pipeline.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_int_pipeline
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TEST RESULT: PASS" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb_int_pipeline.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_int_pipeline;

        // instructions issued per test, used for the run limit
        localparam int N_RESET   = 32;
        localparam int N_R_TYPE  = 71;
        localparam int N_I_TYPE  = 42;
        localparam int N_LUI     = 22;
        localparam int N_B2B     = 30;
        localparam int N_NOWRITE = 39;
        localparam int LIMIT     = (N_RESET + N_R_TYPE + N_I_TYPE + N_LUI + N_B2B + N_NOWRITE) * 4
                                   + 200;

        logic                    clk;
        logic                    reset;
        logic                    instr_valid;
        riscv_pkg::instruction_t instr;
        logic                    wb_valid;
        riscv_pkg::reg_addr_t    wb_rd;
        riscv_pkg::word_t        wb_data;

        riscv_pkg::word_t     model [0:31];     // expected register contents
        riscv_pkg::reg_addr_t exp_rd_q [$];
        riscv_pkg::word_t     exp_data_q [$];

        integer seed;
        int     rd_errors;
        int     data_errors;
        int     flow_errors;
        int     cycles = 0;

        int_pipeline_top dut0 (
                .clk         (clk),
                .reset       (reset),
                .instr_valid (instr_valid),
                .instr       (instr),
                .wb_valid    (wb_valid),
                .wb_rd       (wb_rd),
                .wb_data     (wb_data)
        );

        initial begin
                clk = 1'b0;
                forever #50 clk = ~clk;
        end

        function automatic riscv_pkg::instruction_t r_word(logic [6:0] f7,
                        riscv_pkg::reg_addr_t rs2, riscv_pkg::reg_addr_t rs1, logic [2:0] f3,
                        riscv_pkg::reg_addr_t rd, riscv_pkg::opcode_t opc);
                return {f7, rs2, rs1, f3, rd, opc};
        endfunction

        function automatic riscv_pkg::instruction_t i_word(logic [11:0] imm,
                        riscv_pkg::reg_addr_t rs1, logic [2:0] f3, riscv_pkg::reg_addr_t rd,
                        riscv_pkg::opcode_t opc);
                return {imm, rs1, f3, rd, opc};
        endfunction

        function automatic logic [2:0] funct3_for(riscv_pkg::alu_op_t op);
                case (op)
                        riscv_pkg::ALU_XOR: return riscv_pkg::F3_XOR;
                        riscv_pkg::ALU_OR:  return riscv_pkg::F3_OR;
                        riscv_pkg::ALU_AND: return riscv_pkg::F3_AND;
                        default:            return riscv_pkg::F3_ADD_SUB;
                endcase
        endfunction

        // architectural result of one operation
        function automatic riscv_pkg::word_t alu_ref(riscv_pkg::alu_op_t op,
                        riscv_pkg::word_t a, riscv_pkg::word_t b);
                case (op)
                        riscv_pkg::ALU_SUB: return a - b;
                        riscv_pkg::ALU_XOR: return a ^ b;
                        riscv_pkg::ALU_OR:  return a | b;
                        riscv_pkg::ALU_AND: return a & b;
                        default:            return a + b;
                endcase
        endfunction

        function automatic riscv_pkg::reg_addr_t rand_reg();
                riscv_pkg::word_t w;
                w = $random(seed);
                return w[4:0];
        endfunction

        function automatic logic [11:0] rand_imm12();
                riscv_pkg::word_t w;
                w = $random(seed);
                return w[11:0];
        endfunction

        function automatic riscv_pkg::alu_op_t pick_op(int unsigned count);
                int unsigned n;
                n = $unsigned($random(seed)) % count;
                case (n)
                        0:       return riscv_pkg::ALU_ADD;
                        1:       return riscv_pkg::ALU_XOR;
                        2:       return riscv_pkg::ALU_OR;
                        3:       return riscv_pkg::ALU_AND;
                        default: return riscv_pkg::ALU_SUB;    // only when count is 5
                endcase
        endfunction

        task automatic check_rd(riscv_pkg::reg_addr_t got, riscv_pkg::reg_addr_t exp);
                if (got !== exp) begin
                        $display("FAIL t=%0t: wb_rd is x%0d, expected x%0d", $time, got, exp);
                        rd_errors++;
                end
        endtask

        task automatic check_data(riscv_pkg::word_t got, riscv_pkg::word_t exp);
                if (got !== exp) begin
                        $display("FAIL t=%0t: wb_data is %08h, expected %08h", $time, got, exp);
                        data_errors++;
                end
        endtask

        task automatic send_word(riscv_pkg::instruction_t w);
                @(posedge clk);
                instr_valid <= 1'b1;
                instr       <= w;
        endtask

        task automatic idle(int n);
                repeat (n) begin
                        @(posedge clk);
                        instr_valid <= 1'b0;
                end
        endtask

        // x0 never changes and never reports
        task automatic expect_write(riscv_pkg::reg_addr_t rd, riscv_pkg::word_t value);
                if (rd != '0) begin
                        model[rd] = value;
                        exp_rd_q.push_back(rd);
                        exp_data_q.push_back(value);
                end
        endtask

        task automatic reg_op(riscv_pkg::alu_op_t op, riscv_pkg::reg_addr_t rd,
                        riscv_pkg::reg_addr_t rs1, riscv_pkg::reg_addr_t rs2);
                logic [6:0]       f7;
                riscv_pkg::word_t res;
                f7  = (op == riscv_pkg::ALU_SUB) ? riscv_pkg::F7_SUB : riscv_pkg::F7_BASE;
                res = alu_ref(op, model[rs1], model[rs2]);
                send_word(r_word(f7, rs2, rs1, funct3_for(op), rd, riscv_pkg::OPC_OP));
                expect_write(rd, res);
        endtask

        task automatic imm_op(riscv_pkg::alu_op_t op, riscv_pkg::reg_addr_t rd,
                        riscv_pkg::reg_addr_t rs1, logic [11:0] imm);
                riscv_pkg::word_t res;
                res = alu_ref(op, model[rs1], {{20{imm[11]}}, imm});
                send_word(i_word(imm, rs1, funct3_for(op), rd, riscv_pkg::OPC_OP_IMM));
                expect_write(rd, res);
        endtask

        task automatic load_upper(riscv_pkg::reg_addr_t rd, logic [19:0] imm20);
                send_word({imm20, rd, riscv_pkg::OPC_LUI});
                expect_write(rd, {imm20, 12'h000});
        endtask

        // stop issuing and wait for every expected write-back
        task automatic drain();
                idle(1);
                while (exp_rd_q.size() != 0) begin
                        @(posedge clk);
                end
                idle(4);        // room for a stray report
        endtask

        // any wb_valid with nothing outstanding is caught by the monitor
        task automatic test_reset();
                int r;
                idle(5);
                for (r = 0; r < 32; r++) begin
                        reg_op(riscv_pkg::ALU_ADD, (r == 0) ? 5'd1 : 5'(r), 5'(r), 5'd0);
                end
                drain();
        endtask

        task automatic test_r_type();
                int r;
                for (r = 1; r < 32; r++) begin
                        imm_op(riscv_pkg::ALU_ADD, 5'(r), 5'd0, rand_imm12());
                end
                repeat (40) reg_op(pick_op(5), rand_reg(), rand_reg(), rand_reg());
                drain();
        endtask

        task automatic test_i_type();
                imm_op(riscv_pkg::ALU_ADD, 5'd3, 5'd4, 12'hfff);        // -1
                imm_op(riscv_pkg::ALU_XOR, 5'd7, 5'd3, 12'h800);        // most negative
                repeat (40) imm_op(pick_op(4), rand_reg(), rand_reg(), rand_imm12());
                drain();
        endtask

        task automatic test_lui();
                riscv_pkg::word_t w;
                load_upper(5'd8, 20'hfffff);
                load_upper(5'd9, 20'h00001);
                repeat (20) begin
                        w = $random(seed);
                        load_upper(rand_reg(), w[19:0]);
                end
                drain();
        endtask

        task automatic test_back_to_back();
                int gap;
                int i;
                for (gap = 0; gap < 3; gap++) begin
                        for (i = 0; i < 10; i++) begin
                                case (i % 3)
                                        0:       imm_op(riscv_pkg::ALU_ADD, 5'd5, 5'd5, rand_imm12());
                                        1:       reg_op(riscv_pkg::ALU_ADD, 5'd6, 5'd5, 5'd6);
                                        default: reg_op(riscv_pkg::ALU_SUB, 5'd5, 5'd6, 5'd5);
                                endcase
                                idle(gap);
                        end
                end
                drain();
        endtask

        task automatic test_no_write();
                int r;
                send_word(r_word(7'h00, 5'd3, 5'd2, 3'b010, 5'd4, riscv_pkg::OPC_STORE));
                send_word(r_word(7'h00, 5'd2, 5'd1, 3'b000, 5'd8, riscv_pkg::OPC_BRANCH));
                send_word(r_word(riscv_pkg::F7_BASE, 5'd2, 5'd1, 3'b001, 5'd9, riscv_pkg::OPC_OP));
                send_word(r_word(7'h01, 5'd2, 5'd1, 3'b000, 5'd10, riscv_pkg::OPC_OP)); // mul
                send_word(i_word(12'h005, 5'd1, 3'b010, 5'd11, riscv_pkg::OPC_OP_IMM)); // slti
                imm_op(riscv_pkg::ALU_ADD, 5'd0, 5'd1, 12'h123);
                reg_op(riscv_pkg::ALU_OR, 5'd0, 5'd1, 5'd2);
                load_upper(5'd0, 20'habcde);
                for (r = 1; r < 32; r++) begin
                        reg_op(riscv_pkg::ALU_ADD, 5'(r), 5'(r), 5'd0);
                end
                drain();
        endtask

        always @(negedge clk) begin
                if (!reset && wb_valid) begin
                        if (exp_rd_q.size() == 0) begin
                                $display("ERROR: write-back to x%0d at %0t with none expected",
                                         wb_rd, $time);
                                flow_errors++;
                        end else begin
                                check_rd(wb_rd, exp_rd_q.pop_front());
                                check_data(wb_data, exp_data_q.pop_front());
                        end
                end
        end

        always @(posedge clk) begin
                cycles = cycles + 1;
                if (cycles >= LIMIT) begin
                        $display("ERROR: run stopped after %0d cycles, %0d write-backs missing",
                                 cycles, exp_rd_q.size());
                        $display("TEST RESULT: FAIL");
                        $finish;
                end
        end

        initial begin
                int i;
                seed        = 32'h9b48273c;
                rd_errors   = 0;
                data_errors = 0;
                flow_errors = 0;
                reset       = 1'b1;
                instr_valid = 1'b0;
                instr       = '0;
                for (i = 0; i < 32; i++) begin
                        model[i] = '0;
                end
                repeat (10) @(posedge clk);
                reset <= 1'b0;

                test_reset();
                test_r_type();
                test_i_type();
                test_lui();
                test_back_to_back();
                test_no_write();

                if (exp_rd_q.size() != 0) begin
                        $display("ERROR: %0d expected write-backs never arrived", exp_rd_q.size());
                        flow_errors++;
                end
                $display("errors: rd %0d, data %0d, flow %0d", rd_errors, data_errors,
                         flow_errors);
                if (rd_errors + data_errors + flow_errors == 0) begin
                        $display("TEST RESULT: PASS");
                end else begin
                        $display("TEST RESULT: FAIL");
                end
                $finish;
        end

endmodule

`default_nettype wire

/* int_pipeline_top.sv */
`timescale 1ns/1ps
`default_nettype none

module int_pipeline_top (
        input  logic                    clk,
        input  logic                    reset,
        input  logic                    instr_valid,
        input  riscv_pkg::instruction_t instr,
        output logic                    wb_valid,
        output riscv_pkg::reg_addr_t    wb_rd,
        output riscv_pkg::word_t        wb_data
);

        decode_if  dec_bus ();
        operand_if opnd_bus ();

        riscv_pkg::reg_addr_t raddr1;
        riscv_pkg::reg_addr_t raddr2;
        riscv_pkg::word_t     rdata1;
        riscv_pkg::word_t     rdata2;
        logic                 we;
        riscv_pkg::reg_addr_t waddr;
        riscv_pkg::word_t     wdata;
        logic                 fwd_valid;        // result in execute, not yet written
        riscv_pkg::reg_addr_t fwd_rd;
        riscv_pkg::word_t     fwd_data;

        decode_stage decode0 (
                .clk         (clk),
                .reset       (reset),
                .instr_valid (instr_valid),
                .instr       (instr),
                .dec         (dec_bus.producer)
        );

        reg_file regs0 (
                .clk    (clk),
                .reset  (reset),
                .raddr1 (raddr1),
                .raddr2 (raddr2),
                .waddr  (waddr),
                .we     (we),
                .wdata  (wdata),
                .rdata1 (rdata1),
                .rdata2 (rdata2)
        );

        operand_stage operand0 (
                .clk       (clk),
                .reset     (reset),
                .dec       (dec_bus.consumer),
                .opnd      (opnd_bus.producer),
                .raddr1    (raddr1),
                .raddr2    (raddr2),
                .rdata1    (rdata1),
                .rdata2    (rdata2),
                .fwd_valid (fwd_valid),
                .fwd_rd    (fwd_rd),
                .fwd_data  (fwd_data)
        );

        execute_stage execute0 (
                .clk       (clk),
                .reset     (reset),
                .opnd      (opnd_bus.consumer),
                .we        (we),
                .waddr     (waddr),
                .wdata     (wdata),
                .fwd_valid (fwd_valid),
                .fwd_rd    (fwd_rd),
                .fwd_data  (fwd_data),
                .wb_valid  (wb_valid),
                .wb_rd     (wb_rd),
                .wb_data   (wb_data)
        );

endmodule

`default_nettype wire

/* execute_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
        input  logic                 clk,
        input  logic                 reset,
        operand_if.consumer          opnd,
        output logic                 we,
        output riscv_pkg::reg_addr_t waddr,
        output riscv_pkg::word_t     wdata,
        output logic                 fwd_valid,
        output riscv_pkg::reg_addr_t fwd_rd,
        output riscv_pkg::word_t     fwd_data,
        output logic                 wb_valid,
        output riscv_pkg::reg_addr_t wb_rd,
        output riscv_pkg::word_t     wb_data
);

        riscv_pkg::word_t result;
        logic             wr_en;

        always_comb begin
                case (opnd.ctrl.alu_op)
                        riscv_pkg::ALU_ADD:    result = opnd.op_a + opnd.op_b;  // wraps at 32 bits
                        riscv_pkg::ALU_SUB:    result = opnd.op_a - opnd.op_b;
                        riscv_pkg::ALU_XOR:    result = opnd.op_a ^ opnd.op_b;
                        riscv_pkg::ALU_OR:     result = opnd.op_a | opnd.op_b;
                        riscv_pkg::ALU_AND:    result = opnd.op_a & opnd.op_b;
                        riscv_pkg::ALU_PASS_B: result = opnd.op_b;
                        default:               result = opnd.op_a + opnd.op_b;
                endcase
        end

        // x0 destinations and nops write nothing
        assign wr_en = opnd.valid && opnd.ctrl.reg_write && opnd.ctrl.write_back_id != '0;

        assign fwd_valid = wr_en;
        assign fwd_rd    = opnd.ctrl.write_back_id;
        assign fwd_data  = result;

        // register write lands at the same edge as the report
        assign we    = wr_en;
        assign waddr = opnd.ctrl.write_back_id;
        assign wdata = result;

        always_ff @(posedge clk) begin
                if (reset) begin
                        wb_valid <= 1'b0;
                end else begin
                        wb_valid <= wr_en;
                end
        end

        always_ff @(posedge clk) begin
                if (wr_en) begin
                        wb_rd   <= opnd.ctrl.write_back_id;
                        wb_data <= result;
                end
        end

        // lui results keep the low 12 bits clear
        a_lui_low_zero: assert property (@(posedge clk) disable iff (reset)
                wr_en && opnd.ctrl.alu_op == riscv_pkg::ALU_PASS_B |-> result[11:0] == '0);

        // an i-type immediate reaches execute sign extended from bit 11
        a_imm_sign_extended: assert property (@(posedge clk) disable iff (reset)
                opnd.valid && opnd.ctrl.alu_src && opnd.ctrl.encoding == riscv_pkg::I_TYPE
                |-> opnd.op_b[31:11] == '0 || opnd.op_b[31:11] == '1);

endmodule

`default_nettype wire

/* operand_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module operand_stage (
        input  logic                 clk,
        input  logic                 reset,
        decode_if.consumer           dec,
        operand_if.producer          opnd,
        output riscv_pkg::reg_addr_t raddr1,
        output riscv_pkg::reg_addr_t raddr2,
        input  riscv_pkg::word_t     rdata1,
        input  riscv_pkg::word_t     rdata2,
        input  logic                 fwd_valid,
        input  riscv_pkg::reg_addr_t fwd_rd,
        input  riscv_pkg::word_t     fwd_data
);

        riscv_pkg::word_t src1;
        riscv_pkg::word_t src2;
        riscv_pkg::word_t op_a;
        riscv_pkg::word_t op_b;

        assign raddr1 = dec.rs1;
        assign raddr2 = dec.rs2;

        // result still in execute wins over the register file
        always_comb begin
                src1 = (fwd_valid && fwd_rd != '0 && fwd_rd == dec.rs1) ? fwd_data : rdata1;
                src2 = (fwd_valid && fwd_rd != '0 && fwd_rd == dec.rs2) ? fwd_data : rdata2;
                op_a = (dec.ctrl.encoding == riscv_pkg::U_TYPE) ? '0 : src1; // lui
                op_b = dec.ctrl.alu_src ? dec.imm : src2;
        end

        always_ff @(posedge clk) begin
                if (reset) begin
                        opnd.valid <= 1'b0;
                end else begin
                        opnd.valid <= dec.valid;
                end
        end

        always_ff @(posedge clk) begin
                if (dec.valid) begin
                        opnd.ctrl <= dec.ctrl;
                        opnd.op_a <= op_a;
                        opnd.op_b <= op_b;
                end
        end

endmodule

`default_nettype wire

/* reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file (
        input  logic                 clk,
        input  logic                 reset,
        input  riscv_pkg::reg_addr_t raddr1,
        input  riscv_pkg::reg_addr_t raddr2,
        input  riscv_pkg::reg_addr_t waddr,
        input  logic                 we,
        input  riscv_pkg::word_t     wdata,
        output riscv_pkg::word_t     rdata1,
        output riscv_pkg::word_t     rdata2
);

        riscv_pkg::word_t regs [1:31];  // x0 has no storage

        always_ff @(posedge clk) begin
                if (reset) begin
                        for (int i = 1; i < 32; i++) begin
                                regs[i] <= '0;
                        end
                end else if (we && waddr != '0) begin
                        regs[waddr] <= wdata;
                end
        end

        // combinational reads, x0 reads as zero
        assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
        assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

/* decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
        input  logic                    clk,
        input  logic                    reset,
        input  logic                    instr_valid,
        input  riscv_pkg::instruction_t instr,
        decode_if.producer              dec
);

        riscv_pkg::control_t ctrl;
        riscv_pkg::word_t    imm;

        control ctrl_dec (
                .instruction (instr),
                .ctrl        (ctrl)
        );

        always_comb begin
                case (ctrl.encoding)
                        riscv_pkg::I_TYPE: imm = {{20{instr.i.imm12[11]}}, instr.i.imm12};
                        riscv_pkg::U_TYPE: imm = {instr.u.imm20, 12'b0};
                        default:           imm = '0;
                endcase
        end

        always_ff @(posedge clk) begin
                if (reset) begin
                        dec.valid <= 1'b0;
                end else begin
                        dec.valid <= instr_valid;
                end
        end

        // payload only moves on a strobe
        always_ff @(posedge clk) begin
                if (instr_valid) begin
                        dec.ctrl <= ctrl;
                        dec.rs1  <= instr.r.rs1;
                        dec.rs2  <= instr.r.rs2;
                        dec.imm  <= imm;
                end
        end

        // register ops never leave decode with the immediate selected
        a_no_imm_on_r_type: assert property (@(posedge clk) disable iff (reset)
                instr_valid && ctrl.encoding == riscv_pkg::R_TYPE |=> !dec.ctrl.alu_src);

endmodule

`default_nettype wire

/* control.sv */
`timescale 1ns/1ps
`default_nettype none

module control (
        input  riscv_pkg::instruction_t instruction,
        output riscv_pkg::control_t     ctrl
);

        always_comb begin : control_main_comb
                ctrl               = '0;
                ctrl.alu_op        = riscv_pkg::ALU_ADD;
                ctrl.write_back_id = instruction.r.rd;

                // encoding from the major opcode
                case (instruction.r.opcode)
                        riscv_pkg::OPC_OP: begin
                                ctrl.encoding = riscv_pkg::R_TYPE;
                        end
                        riscv_pkg::OPC_OP_IMM: begin
                                ctrl.encoding = riscv_pkg::I_TYPE;
                        end
                        riscv_pkg::OPC_STORE: begin
                                ctrl.encoding = riscv_pkg::S_TYPE;
                        end
                        riscv_pkg::OPC_BRANCH: begin
                                ctrl.encoding = riscv_pkg::B_TYPE;
                        end
                        riscv_pkg::OPC_LUI: begin
                                ctrl.encoding = riscv_pkg::U_TYPE;
                        end
                        riscv_pkg::OPC_JAL: begin
                                ctrl.encoding = riscv_pkg::J_TYPE;
                        end
                        default: begin
                                ctrl.encoding = riscv_pkg::R_TYPE; // treated as nop
                        end
                endcase

                // supported operations, anything else keeps the nop fields
                case (instruction.r.opcode)
                        riscv_pkg::OPC_OP: begin
                                if (instruction.r.funct7 == riscv_pkg::F7_BASE) begin
                                        ctrl.reg_write = 1'b1;
                                        case (instruction.r.funct3)
                                                riscv_pkg::F3_ADD_SUB: ctrl.alu_op = riscv_pkg::ALU_ADD;
                                                riscv_pkg::F3_XOR:     ctrl.alu_op = riscv_pkg::ALU_XOR;
                                                riscv_pkg::F3_OR:      ctrl.alu_op = riscv_pkg::ALU_OR;
                                                riscv_pkg::F3_AND:     ctrl.alu_op = riscv_pkg::ALU_AND;
                                                default:               ctrl.reg_write = 1'b0; // shifts, slt
                                        endcase
                                end else if (instruction.r.funct7 == riscv_pkg::F7_SUB &&
                                             instruction.r.funct3 == riscv_pkg::F3_ADD_SUB) begin
                                        ctrl.alu_op    = riscv_pkg::ALU_SUB;
                                        ctrl.reg_write = 1'b1;
                                end
                        end
                        riscv_pkg::OPC_OP_IMM: begin
                                ctrl.alu_src   = 1'b1;  // imm to alu
                                ctrl.reg_write = 1'b1;
                                case (instruction.i.funct3)
                                        riscv_pkg::F3_ADD_SUB: ctrl.alu_op = riscv_pkg::ALU_ADD;
                                        riscv_pkg::F3_XOR:     ctrl.alu_op = riscv_pkg::ALU_XOR;
                                        riscv_pkg::F3_OR:      ctrl.alu_op = riscv_pkg::ALU_OR;
                                        riscv_pkg::F3_AND:     ctrl.alu_op = riscv_pkg::ALU_AND;
                                        default: begin
                                                ctrl.alu_src   = 1'b0;
                                                ctrl.reg_write = 1'b0;
                                        end
                                endcase
                        end
                        riscv_pkg::OPC_LUI: begin
                                ctrl.alu_op    = riscv_pkg::ALU_PASS_B;
                                ctrl.alu_src   = 1'b1;
                                ctrl.reg_write = 1'b1;
                        end
                        default: begin
                                // nop (addi x0, x0, 0)
                        end
                endcase
        end

endmodule

`default_nettype wire

/* operand_if.sv */
`timescale 1ns/1ps
`default_nettype none

// resolved operands on their way to execute
interface operand_if;

        logic                valid;     // one strobe per instruction
        riscv_pkg::control_t ctrl;
        riscv_pkg::word_t    op_a;
        riscv_pkg::word_t    op_b;      // immediate or rs2 value

        modport producer (
                output valid, ctrl, op_a, op_b
        );

        modport consumer (
                input valid, ctrl, op_a, op_b
        );

endinterface

`default_nettype wire

/* decode_if.sv */
`timescale 1ns/1ps
`default_nettype none

// decoded fields, registered in the decode stage
interface decode_if;

        logic                 valid;    // one strobe per instruction
        riscv_pkg::control_t  ctrl;
        riscv_pkg::reg_addr_t rs1;
        riscv_pkg::reg_addr_t rs2;
        riscv_pkg::word_t     imm;      // sign extended, or shifted up for lui

        modport producer (
                output valid, ctrl, rs1, rs2, imm
        );

        modport consumer (
                input valid, ctrl, rs1, rs2, imm
        );

endinterface

`default_nettype wire

/* riscv_pkg.sv */
`default_nettype none

package riscv_pkg;

        typedef logic [31:0] word_t;
        typedef logic [4:0]  reg_addr_t;
        typedef logic [6:0]  opcode_t;

        // the three views of one instruction word
        typedef struct packed {
                logic [6:0] funct7;
                reg_addr_t  rs2;
                reg_addr_t  rs1;
                logic [2:0] funct3;
                reg_addr_t  rd;
                opcode_t    opcode;
        } r_type_t;

        typedef struct packed {
                logic [11:0] imm12;     // sign bit at 11
                reg_addr_t   rs1;
                logic [2:0]  funct3;
                reg_addr_t   rd;
                opcode_t     opcode;
        } i_type_t;

        typedef struct packed {
                logic [19:0] imm20;     // lands in bits 31:12
                reg_addr_t   rd;
                opcode_t     opcode;
        } u_type_t;

        typedef union packed {
                r_type_t r;
                i_type_t i;
                u_type_t u;
        } instruction_t;

        typedef enum logic [2:0] {
                R_TYPE = 3'd0,
                I_TYPE = 3'd1,
                S_TYPE = 3'd2,
                B_TYPE = 3'd3,
                U_TYPE = 3'd4,
                J_TYPE = 3'd5
        } encoding_t;

        typedef enum logic [2:0] {
                ALU_ADD    = 3'd0,
                ALU_SUB    = 3'd1,
                ALU_XOR    = 3'd2,
                ALU_OR     = 3'd3,
                ALU_AND    = 3'd4,
                ALU_PASS_B = 3'd5     // lui result is operand b
        } alu_op_t;

        typedef struct packed {
                alu_op_t   alu_op;
                encoding_t encoding;
                logic      alu_src;       // operand b from the immediate
                logic      reg_write;
                reg_addr_t write_back_id; // destination register
        } control_t;

        // major opcodes
        localparam opcode_t OPC_OP     = 7'b0110011;
        localparam opcode_t OPC_OP_IMM = 7'b0010011;
        localparam opcode_t OPC_LUI    = 7'b0110111;
        localparam opcode_t OPC_STORE  = 7'b0100011;
        localparam opcode_t OPC_BRANCH = 7'b1100011;
        localparam opcode_t OPC_JAL    = 7'b1101111;

        localparam logic [2:0] F3_ADD_SUB = 3'b000;
        localparam logic [2:0] F3_XOR     = 3'b100;
        localparam logic [2:0] F3_OR      = 3'b110;
        localparam logic [2:0] F3_AND     = 3'b111;

        localparam logic [6:0] F7_BASE = 7'b0000000;
        localparam logic [6:0] F7_SUB  = 7'b0100000;

endpackage

`default_nettype wire
